// ==== isaPkg.sv ====
package isaPkg;

	// Basic widths
	localparam int dataW = 32;
	localparam int addrW = 12;    // Byte address
	localparam int regIdxW = 5;
	localparam int immW = 14;     // Signed immediate field

	typedef logic [dataW-1:0] word_t;
	typedef logic [addrW-1:0] addr_t;
	typedef logic [regIdxW-1:0] regIdx_t;
	typedef logic [31:0] instr_t;

	// Instruction field positions
	localparam int opMsb = 7;
	localparam int opLsb = 0;
	localparam int rdMsb = 31;     // Also store data register
	localparam int rdLsb = 27;
	localparam int raMsb = 26;
	localparam int raLsb = 22;
	localparam int rbMsb = 21;
	localparam int rbLsb = 17;
	localparam int immMsb = 21;    // Overlaps rb
	localparam int immLsb = 8;
	localparam int shamtMsb = 16;
	localparam int shamtLsb = 12;

	localparam int pcStep = 4;     // One word per instruction

	// Opcode byte, anything unlisted behaves as nop
	typedef enum logic [7:0] {
		opNop   = 8'h00,
		opAdd   = 8'h01,
		opSub   = 8'h02,
		opMul   = 8'h03,
		opXor   = 8'h04,
		opOr    = 8'h05,
		opAnd   = 8'h06,
		opSll   = 8'h07,
		opSra   = 8'h08,
		opSrl   = 8'h09,
		opSle   = 8'h0A,
		opAddi  = 8'h10,
		opSlli  = 8'h11,
		opSrai  = 8'h12,
		opSrli  = 8'h13,
		opLoad  = 8'h20,
		opStore = 8'h21
	} opcode_e;

	typedef enum logic [3:0] {
		aluAdd = 4'd0,
		aluSub = 4'd1,
		aluMul = 4'd2,
		aluXor = 4'd3,
		aluOr  = 4'd4,
		aluAnd = 4'd5,
		aluSll = 4'd6,
		aluSra = 4'd7,
		aluSrl = 4'd8,
		aluSle = 4'd9
	} aluOp_e;

	// Second ALU operand source
	typedef enum logic [1:0] {
		srcReg   = 2'd0,
		srcImm   = 2'd1,
		srcShamt = 2'd2
	} srcB_e;

endpackage

// ==== pipePkg.sv ====
package pipePkg;

	// Control bundle produced by decode
	typedef struct packed {
		isaPkg::aluOp_e aluOp;
		isaPkg::srcB_e srcB;
		logic memRead;
		logic memWrite;
		logic regWrite;
		logic memToReg;        // Writeback takes load data
	} ctrl_t;

	typedef struct packed {
		isaPkg::instr_t instr;
		isaPkg::addr_t pcNext;   // PC of the following instruction
	} ifId_t;

	typedef struct packed {
		ctrl_t ctrl;
		isaPkg::regIdx_t ra;
		isaPkg::regIdx_t rb;     // rd field for stores
		isaPkg::regIdx_t rd;
		isaPkg::word_t da;
		isaPkg::word_t db;
		isaPkg::word_t imm;      // Already sign extended
		isaPkg::regIdx_t shamt;
		isaPkg::regIdx_t storeSrc;
	} idEx_t;

	typedef struct packed {
		logic memRead;
		logic memWrite;
		logic regWrite;
		logic memToReg;
		isaPkg::word_t aluResult;  // Also the data address
		isaPkg::word_t storeData;
		isaPkg::regIdx_t rd;
		isaPkg::regIdx_t storeSrc;
	} exMem_t;

	typedef struct packed {
		logic regWrite;
		logic memToReg;
		isaPkg::word_t loadData;
		isaPkg::word_t aluResult;
		isaPkg::regIdx_t rd;
	} memWb_t;

	// Operand forwarding source
	typedef enum logic [1:0] {
		fwdNone = 2'd0,
		fwdWb   = 2'd1,
		fwdMem  = 2'd2
	} fwdSel_e;

endpackage

// ==== fetchStage.sv ====
`timescale 1ns/10ps

module fetchStage (
	input logic clk,
	input logic reset,
	input logic freeze,
	input logic loadStall,
	input isaPkg::instr_t icacheInstr,
	output isaPkg::addr_t icachePc,
	output pipePkg::ifId_t ifIdReg
);

	isaPkg::addr_t pc;
	isaPkg::addr_t pcNext;
	logic hold;

	assign hold = freeze | loadStall;   // Either stall keeps fetch in place
	assign pcNext = pc + isaPkg::addr_t'(isaPkg::pcStep);
	assign icachePc = pc;               // Instruction comes back same cycle

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= '0;
		end else if (!hold) begin
			pc <= pcNext;
		end
	end

	// Fetch/decode register, bubble is an all-zero nop word
	always_ff @(posedge clk) begin
		if (reset) begin
			ifIdReg <= '0;
		end else if (!hold) begin
			ifIdReg.instr <= icacheInstr;
			ifIdReg.pcNext <= pcNext;
		end
	end

endmodule

// ==== regFile.sv ====
`timescale 1ns/10ps

module regFile (
	input logic clk,
	input logic reset,
	input isaPkg::regIdx_t raIdx,
	input isaPkg::regIdx_t rbIdx,
	input isaPkg::regIdx_t wbIdx,
	input logic wbEn,
	input isaPkg::word_t wbData,
	output isaPkg::word_t raData,
	output isaPkg::word_t rbData
);

	isaPkg::word_t regs [32];
	logic wbLive;

	assign wbLive = wbEn && (wbIdx != '0);   // r0 is never written

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wbLive) begin
			regs[wbIdx] <= wbData;
		end
	end

	// Reads see a write landing this cycle
	always_comb begin
		if (raIdx == '0) begin
			raData = '0;
		end else if (wbLive && wbIdx == raIdx) begin
			raData = wbData;   // Bypass
		end else begin
			raData = regs[raIdx];
		end
		if (rbIdx == '0) begin
			rbData = '0;
		end else if (wbLive && wbIdx == rbIdx) begin
			rbData = wbData;
		end else begin
			rbData = regs[rbIdx];
		end
	end

endmodule

// ==== decodeStage.sv ====
`timescale 1ns/10ps

module decodeStage (
	input logic clk,
	input logic reset,
	input logic freeze,
	input logic loadStall,
	input pipePkg::ifId_t ifIdReg,
	input isaPkg::word_t raData,
	input isaPkg::word_t rbData,
	output isaPkg::regIdx_t raIdx,
	output isaPkg::regIdx_t rbIdx,
	output pipePkg::idEx_t idExReg
);

	isaPkg::opcode_e opcode;
	isaPkg::regIdx_t rdIdx;
	logic [isaPkg::immW-1:0] immField;
	isaPkg::word_t immExt;
	pipePkg::ctrl_t ctrl;

	// Field extraction
	assign opcode = isaPkg::opcode_e'(ifIdReg.instr[isaPkg::opMsb:isaPkg::opLsb]);
	assign rdIdx = ifIdReg.instr[isaPkg::rdMsb:isaPkg::rdLsb];
	assign raIdx = ifIdReg.instr[isaPkg::raMsb:isaPkg::raLsb];
	assign rbIdx = (opcode == isaPkg::opStore) ? rdIdx    // Store data sits in rd field
		: ifIdReg.instr[isaPkg::rbMsb:isaPkg::rbLsb];
	assign immField = ifIdReg.instr[isaPkg::immMsb:isaPkg::immLsb];
	assign immExt = {{(isaPkg::dataW - isaPkg::immW){immField[isaPkg::immW-1]}}, immField};

	// Opcode to control
	always_comb begin
		ctrl = '0;   // Unknown codes end up as nop
		case (opcode)
			isaPkg::opAdd, isaPkg::opSub, isaPkg::opMul, isaPkg::opXor, isaPkg::opOr,
			isaPkg::opAnd, isaPkg::opSll, isaPkg::opSra, isaPkg::opSrl, isaPkg::opSle: begin
				ctrl.regWrite = 1'b1;
				ctrl.srcB = isaPkg::srcReg;
			end
			isaPkg::opAddi: begin
				ctrl.regWrite = 1'b1;
				ctrl.srcB = isaPkg::srcImm;
			end
			isaPkg::opSlli, isaPkg::opSrai, isaPkg::opSrli: begin
				ctrl.regWrite = 1'b1;
				ctrl.srcB = isaPkg::srcShamt;
			end
			isaPkg::opLoad: begin
				ctrl.regWrite = 1'b1;
				ctrl.memRead = 1'b1;
				ctrl.memToReg = 1'b1;
				ctrl.srcB = isaPkg::srcImm;   // Address is ra + imm
			end
			isaPkg::opStore: begin
				ctrl.memWrite = 1'b1;
				ctrl.srcB = isaPkg::srcImm;
			end
			default: ctrl = '0;
		endcase
		case (opcode)   // ALU function, add covers nop and memory ops
			isaPkg::opSub: ctrl.aluOp = isaPkg::aluSub;
			isaPkg::opMul: ctrl.aluOp = isaPkg::aluMul;
			isaPkg::opXor: ctrl.aluOp = isaPkg::aluXor;
			isaPkg::opOr: ctrl.aluOp = isaPkg::aluOr;
			isaPkg::opAnd: ctrl.aluOp = isaPkg::aluAnd;
			isaPkg::opSll, isaPkg::opSlli: ctrl.aluOp = isaPkg::aluSll;
			isaPkg::opSra, isaPkg::opSrai: ctrl.aluOp = isaPkg::aluSra;
			isaPkg::opSrl, isaPkg::opSrli: ctrl.aluOp = isaPkg::aluSrl;
			isaPkg::opSle: ctrl.aluOp = isaPkg::aluSle;
			default: ctrl.aluOp = isaPkg::aluAdd;
		endcase
	end

	// Decode/execute register
	always_ff @(posedge clk) begin
		if (reset) begin
			idExReg <= '0;
		end else if (freeze) begin
			idExReg <= idExReg;       // Whole pipe waits on data port
		end else if (loadStall) begin
			idExReg <= '0;            // Bubble behind the load
		end else begin
			idExReg.ctrl <= ctrl;
			idExReg.ra <= raIdx;
			idExReg.rb <= rbIdx;
			idExReg.rd <= rdIdx;
			idExReg.da <= raData;
			idExReg.db <= rbData;
			idExReg.imm <= immExt;
			idExReg.shamt <= ifIdReg.instr[isaPkg::shamtMsb:isaPkg::shamtLsb];
			idExReg.storeSrc <= rdIdx;
		end
	end

endmodule

// ==== hazardUnit.sv ====
`timescale 1ns/10ps

module hazardUnit (
	input isaPkg::regIdx_t raIdx,
	input isaPkg::regIdx_t rbIdx,
	input pipePkg::idEx_t idExReg,
	input pipePkg::exMem_t exMemReg,
	input pipePkg::memWb_t memWbReg,
	input logic dcacheReady,
	output logic freeze,
	output logic loadStall,
	output pipePkg::fwdSel_e fwdA,
	output pipePkg::fwdSel_e fwdB
);

	logic memAccess;

	// Newest producer wins, r0 never forwarded
	function automatic pipePkg::fwdSel_e pickFwd(input isaPkg::regIdx_t src);
		if (src == '0) begin
			return pipePkg::fwdNone;
		end
		if (exMemReg.regWrite && exMemReg.rd == src) begin
			return pipePkg::fwdMem;
		end
		if (memWbReg.regWrite && memWbReg.rd == src) begin
			return pipePkg::fwdWb;
		end
		return pipePkg::fwdNone;
	endfunction

	assign memAccess = exMemReg.memRead | exMemReg.memWrite;
	assign freeze = memAccess && !dcacheReady;   // Hold until ready pulse

	// Load in execute feeding the instruction in decode
	assign loadStall = idExReg.ctrl.memRead && (idExReg.rd != '0)
		&& (idExReg.rd == raIdx || idExReg.rd == rbIdx);

	always_comb begin
		fwdA = pickFwd(idExReg.ra);
		fwdB = pickFwd(idExReg.rb);   // Also covers store data
	end

endmodule

// ==== executeStage.sv ====
`timescale 1ns/10ps

module executeStage (
	input logic clk,
	input logic reset,
	input logic freeze,
	input pipePkg::idEx_t idExReg,
	input pipePkg::fwdSel_e fwdA,
	input pipePkg::fwdSel_e fwdB,
	input isaPkg::word_t wbData,
	output pipePkg::exMem_t exMemReg
);

	isaPkg::word_t opA;
	isaPkg::word_t rbVal;       // rb after forwarding
	isaPkg::word_t opB;
	isaPkg::word_t aluOut;
	logic [4:0] shAmt;

	function automatic isaPkg::word_t fwdMux(input pipePkg::fwdSel_e sel,
		input isaPkg::word_t regVal,
		input isaPkg::word_t memVal,
		input isaPkg::word_t wbVal);
		case (sel)
			pipePkg::fwdMem: return memVal;
			pipePkg::fwdWb: return wbVal;
			default: return regVal;
		endcase
	endfunction

	assign opA = fwdMux(fwdA, idExReg.da, exMemReg.aluResult, wbData);
	assign rbVal = fwdMux(fwdB, idExReg.db, exMemReg.aluResult, wbData);

	always_comb begin
		case (idExReg.ctrl.srcB)
			isaPkg::srcImm: opB = idExReg.imm;
			isaPkg::srcShamt: opB = {{(isaPkg::dataW - isaPkg::regIdxW){1'b0}}, idExReg.shamt};
			default: opB = rbVal;
		endcase
	end

	assign shAmt = opB[4:0];   // Only low bits shift

	always_comb begin
		case (idExReg.ctrl.aluOp)
			isaPkg::aluSub: aluOut = opA - opB;
			isaPkg::aluMul: aluOut = opA * opB;   // Low word kept
			isaPkg::aluXor: aluOut = opA ^ opB;
			isaPkg::aluOr: aluOut = opA | opB;
			isaPkg::aluAnd: aluOut = opA & opB;
			isaPkg::aluSll: aluOut = opA << shAmt;
			isaPkg::aluSra: aluOut = isaPkg::word_t'($signed(opA) >>> shAmt);
			isaPkg::aluSrl: aluOut = opA >> shAmt;
			isaPkg::aluSle: aluOut = (opA <= opB) ? 32'd1 : 32'd0;   // Unsigned compare
			default: aluOut = opA + opB;
		endcase
	end

	// Execute/memory register
	always_ff @(posedge clk) begin
		if (reset) begin
			exMemReg <= '0;
		end else if (!freeze) begin
			exMemReg.memRead <= idExReg.ctrl.memRead;
			exMemReg.memWrite <= idExReg.ctrl.memWrite;
			exMemReg.regWrite <= idExReg.ctrl.regWrite;
			exMemReg.memToReg <= idExReg.ctrl.memToReg;
			exMemReg.aluResult <= aluOut;
			exMemReg.storeData <= rbVal;
			exMemReg.rd <= idExReg.rd;
			exMemReg.storeSrc <= idExReg.storeSrc;
		end
	end

endmodule

// ==== memStage.sv ====
`timescale 1ns/10ps

module memStage (
	input logic clk,
	input logic reset,
	input logic freeze,
	input pipePkg::exMem_t exMemReg,
	input isaPkg::word_t dcacheReadData,
	output logic dcacheRequest,
	output logic dcacheWrite,
	output isaPkg::addr_t dcacheAddress,
	output isaPkg::word_t dcacheWriteData,
	output isaPkg::word_t wbData,
	output isaPkg::regIdx_t wbIdx,
	output logic wbEn
);

	pipePkg::memWb_t memWbReg;

	// Data port request held as a level until ready
	assign dcacheRequest = exMemReg.memRead | exMemReg.memWrite;
	assign dcacheWrite = exMemReg.memWrite;
	assign dcacheAddress = exMemReg.aluResult[isaPkg::addrW-1:0];
	assign dcacheWriteData = exMemReg.storeData;   // Forwarded in execute

	// Memory/writeback register
	always_ff @(posedge clk) begin
		if (reset) begin
			memWbReg <= '0;
		end else if (!freeze) begin
			memWbReg.regWrite <= exMemReg.regWrite;
			memWbReg.memToReg <= exMemReg.memToReg;
			memWbReg.loadData <= dcacheReadData;   // Valid in the ready cycle
			memWbReg.aluResult <= exMemReg.aluResult;
			memWbReg.rd <= exMemReg.rd;
		end
	end

	assign wbData = memWbReg.memToReg ? memWbReg.loadData : memWbReg.aluResult;
	assign wbIdx = memWbReg.rd;
	assign wbEn = memWbReg.regWrite;

endmodule

// ==== cpuCore.sv ====
`timescale 1ns/10ps

module cpuCore (
	input logic clk,
	input logic reset,
	output isaPkg::addr_t icachePc,
	input isaPkg::instr_t icacheInstr,
	output logic dcacheRequest,
	output logic dcacheWrite,
	output isaPkg::addr_t dcacheAddress,
	output isaPkg::word_t dcacheWriteData,
	input isaPkg::word_t dcacheReadData,
	input logic dcacheReady
);

	// Stage registers
	pipePkg::ifId_t ifIdReg;
	pipePkg::idEx_t idExReg;
	pipePkg::exMem_t exMemReg;
	pipePkg::memWb_t memWbReg;

	// Hazard controls
	logic freeze;
	logic loadStall;
	pipePkg::fwdSel_e fwdA;
	pipePkg::fwdSel_e fwdB;

	// Register file traffic
	isaPkg::regIdx_t raIdx;
	isaPkg::regIdx_t rbIdx;
	isaPkg::word_t raData;
	isaPkg::word_t rbData;
	isaPkg::word_t wbData;
	isaPkg::regIdx_t wbIdx;
	logic wbEn;

	fetchStage fetch0 (
		.clk, .reset, .freeze, .loadStall,
		.icacheInstr, .icachePc, .ifIdReg
	);

	regFile regs0 (
		.clk, .reset, .raIdx, .rbIdx,
		.wbIdx, .wbEn, .wbData, .raData, .rbData
	);

	decodeStage decode0 (
		.clk, .reset, .freeze, .loadStall, .ifIdReg,
		.raData, .rbData, .raIdx, .rbIdx, .idExReg
	);

	hazardUnit hazard0 (
		.raIdx, .rbIdx, .idExReg, .exMemReg, .memWbReg,
		.dcacheReady, .freeze, .loadStall, .fwdA, .fwdB
	);

	executeStage execute0 (
		.clk, .reset, .freeze, .idExReg,
		.fwdA, .fwdB, .wbData, .exMemReg
	);

	// memWbReg lives inside, tapped back out for the hazard unit
	memStage mem0 (
		.clk, .reset, .freeze, .exMemReg, .dcacheReadData,
		.dcacheRequest, .dcacheWrite, .dcacheAddress, .dcacheWriteData,
		.wbData, .wbIdx, .wbEn
	);
	assign memWbReg = mem0.memWbReg;

endmodule

// ==== cpuModel.svh ====
`ifndef CPU_MODEL_SVH
`define CPU_MODEL_SVH

localparam int progLen = 200;
localparam int memWords = 64;

// One data-port access as the model expects it
typedef struct packed {
	logic write;
	isaPkg::addr_t addr;
	isaPkg::word_t data;    // Store data, zero for loads
	logic [1:0] group;      // Behavior group of the data value
} access_t;

isaPkg::instr_t progMem [1024];   // Whole 4 KB fetch space
isaPkg::word_t archRegs [32];
isaPkg::word_t modelMem [memWords];
int regGroup [32];                // Group of each register's last writer
access_t expAccess [$];
integer seed;

function automatic isaPkg::word_t fillWord(input int idx);
	return (idx * 32'h9E37_79B9) ^ 32'h5A5A_0000;   // Every index bit matters
endfunction

// Reference ALU, shifts use the low five bits
function automatic isaPkg::word_t refAlu(input isaPkg::opcode_e op, input isaPkg::word_t a,
	input isaPkg::word_t b);
	case (op)
		isaPkg::opSub: return a - b;
		isaPkg::opMul: return a * b;
		isaPkg::opXor: return a ^ b;
		isaPkg::opOr: return a | b;
		isaPkg::opAnd: return a & b;
		isaPkg::opSll, isaPkg::opSlli: return a << b[4:0];
		isaPkg::opSra, isaPkg::opSrai: return isaPkg::word_t'($signed(a) >>> b[4:0]);
		isaPkg::opSrl, isaPkg::opSrli: return a >> b[4:0];
		isaPkg::opSle: return (a <= b) ? 32'd1 : 32'd0;   // Unsigned compare
		default: return a + b;                             // Also memory addresses
	endcase
endfunction

// Random program, executed in order as it is generated
task automatic buildProgram;
	isaPkg::opcode_e op;
	isaPkg::regIdx_t rd, ra, rb, loadRd;
	logic [13:0] imm;
	logic [4:0] sh;
	isaPkg::word_t b, res;
	int pick, group;
	logic prevLoad;
	access_t acc;
	for (int i = 0; i < 1024; i++) progMem[i] = '0;   // Nops after the program
	for (int i = 0; i < 32; i++) begin
		archRegs[i] = '0;
		regGroup[i] = 3;    // Untouched registers still read zero
	end
	for (int i = 0; i < memWords; i++) modelMem[i] = fillWord(i);
	prevLoad = 1'b0;
	loadRd = '0;
	for (int i = 0; i < progLen; i++) begin
		pick = $unsigned($random(seed)) % 16;
		rd = 5'($unsigned($random(seed)) % 8);   // Small register set, lots of hazards
		ra = 5'($unsigned($random(seed)) % 8);
		rb = 5'($unsigned($random(seed)) % 8);
		imm = 14'($random(seed));
		sh = 5'($random(seed));
		if (pick < 6) begin
			op = isaPkg::opcode_e'(8'(1 + $unsigned($random(seed)) % 10));
			b = archRegs[rb];
			progMem[i] = {rd, ra, rb, 9'd0, op};
		end else if (pick < 8) begin
			op = isaPkg::opAddi;
			b = {{18{imm[13]}}, imm};   // Negative immediates too
			progMem[i] = {rd, ra, imm, op};
		end else if (pick < 11) begin
			op = isaPkg::opcode_e'(8'(8'h11 + $unsigned($random(seed)) % 3));
			b = {27'd0, sh};
			progMem[i] = {rd, ra, rb, sh, 4'd0, op};
		end else begin
			op = (pick < 13) ? isaPkg::opLoad : isaPkg::opStore;
			ra = '0;
			imm = {6'd0, 6'($random(seed)), 2'b00};   // Word aligned, below 256
			b = {18'd0, imm};
			progMem[i] = {rd, ra, imm, op};
		end
		res = refAlu(op, archRegs[ra], b);
		group = (pick < 6) ? 0 : 1;
		if (prevLoad && loadRd != '0 && (ra == loadRd || (pick < 6 && rb == loadRd)))
			group = 2;   // Consumer right behind a load
		if (op == isaPkg::opLoad || op == isaPkg::opStore) begin
			acc.write = (op == isaPkg::opStore);
			acc.addr = res[11:0];
			acc.data = acc.write ? archRegs[rd] : '0;
			acc.group = acc.write ? 2'(regGroup[rd]) : 2'd2;
			expAccess.push_back(acc);
			if (acc.write)
				modelMem[res[7:2]] = archRegs[rd];
			else
				res = modelMem[res[7:2]];
			group = 2;
		end
		if (op != isaPkg::opStore && rd != '0) begin   // r0 stays zero
			archRegs[rd] = res;
			regGroup[rd] = group;
		end
		prevLoad = (op == isaPkg::opLoad);
		loadRd = rd;
	end
endtask

`endif

// ==== tbCpuCore.sv ====
`timescale 1ns/10ps

module tbCpuCore;

	`include "cpuModel.svh"

	localparam int cycleLimit = progLen * 6 + 100;   // Six cycles per instruction worst case

	logic clk;
	logic reset;
	isaPkg::addr_t icachePc;
	isaPkg::instr_t icacheInstr;
	logic dcacheRequest;
	logic dcacheWrite;
	isaPkg::addr_t dcacheAddress;
	isaPkg::word_t dcacheWriteData;
	isaPkg::word_t dcacheReadData;
	logic dcacheReady;

	isaPkg::word_t respMem [memWords];   // Responder side data memory
	int passCount;
	int errCount;
	int cycleCount;
	int accessCount;
	int expCount;
	int checks [6];
	int fails [6];
	int waitCnt;
	int waitTarget;
	logic waiting;

	cpuCore dut0 (
		.clk, .reset, .icachePc, .icacheInstr,
		.dcacheRequest, .dcacheWrite, .dcacheAddress, .dcacheWriteData,
		.dcacheReadData, .dcacheReady
	);

	assign icacheInstr = progMem[icachePc[11:2]];   // Same-cycle instruction return

	always #4 clk = ~clk;

	function automatic string groupTitle(input int g);
		case (g)
			0: return "Register-form ALU with forwarding";
			1: return "Immediate and shift-amount forms";
			2: return "Load-use stall";
			3: return "r0 reads and writes";
			4: return "Reset state";
			default: return "Access count and order under ready delays";
		endcase
	endfunction

	task automatic compareWord(input string sigName, input logic [31:0] got,
		input logic [31:0] exp, input int g);
		checks[g]++;
		assert (got === exp) passCount++;
		else begin
			$display("ERR %0t %s got %h expected %h", $time, sigName, got, exp);
			errCount++;
			fails[g]++;
		end
	endtask

	// One completed access against the model's next one
	task automatic recordAccess;
		access_t exp;
		assert (accessCount < expCount) begin
			exp = expAccess[accessCount];
			compareWord("dcacheWrite", 32'(dcacheWrite), 32'(exp.write), 5);
			compareWord("dcacheAddress", 32'(dcacheAddress), 32'(exp.addr), 5);
			if (exp.write)
				compareWord("dcacheWriteData", dcacheWriteData, exp.data, int'(exp.group));
		end else begin
			$display("Data access at %0t goes beyond the %0d the program makes",
				$time, expCount);
			errCount++;
			fails[5]++;
		end
		accessCount++;
	endtask

	task automatic reportGroup(input int g);
		$display("%s: %0d checks, %0d errors", groupTitle(g), checks[g], fails[g]);
	endtask

	always @(posedge clk) begin
		cycleCount++;
		if (cycleCount >= cycleLimit) begin
			$display("Run timed out after %0d cycles with %0d of %0d data accesses done",
				cycleCount, accessCount, expCount);
			$display("Simulation failed");
			$finish;
		end
	end

	// Data responder raising ready after a random wait
	always @(posedge clk) begin
		if (reset) begin
			dcacheReady <= 1'b0;
			waiting = 1'b0;
			waitCnt = 0;
		end else if (dcacheReady) begin
			recordAccess();   // Request and ready both high last cycle
			if (dcacheWrite)
				respMem[dcacheAddress[7:2]] = dcacheWriteData;
			dcacheReady <= 1'b0;
			waiting = 1'b0;
		end else if (dcacheRequest) begin
			if (!waiting) begin
				waiting = 1'b1;
				waitCnt = 0;
				waitTarget = $unsigned($random(seed)) % 4;
			end
			if (waitCnt >= waitTarget) begin
				dcacheReady <= 1'b1;
				dcacheReadData <= respMem[dcacheAddress[7:2]];
			end else begin
				waitCnt++;
			end
		end
	end

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		dcacheReady = 1'b0;
		dcacheReadData = '0;
		passCount = 0;
		errCount = 0;
		cycleCount = 0;
		accessCount = 0;
		for (int g = 0; g < 6; g++) begin
			checks[g] = 0;
			fails[g] = 0;
		end
		seed = 93567;
		buildProgram();
		expCount = expAccess.size();
		for (int i = 0; i < memWords; i++) respMem[i] = fillWord(i);
		repeat (2) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);   // First cycle out of reset
		compareWord("icachePc", 32'(icachePc), 32'd0, 4);
		compareWord("dcacheRequest", 32'(dcacheRequest), 32'd0, 4);
		compareWord("dcacheWrite", 32'(dcacheWrite), 32'd0, 4);
		reportGroup(4);
		while (accessCount < expCount) @(posedge clk);
		repeat (20) @(posedge clk);   // Room for a stray extra access
		compareWord("accessCount", 32'(accessCount), 32'(expCount), 5);
		for (int g = 0; g < 4; g++) reportGroup(g);
		reportGroup(5);
		$display("Checks passed: %0d, errors: %0d", passCount, errCount);
		if (errCount == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// ==== cpuCore.f ====
+incdir+.
isaPkg.sv
pipePkg.sv
fetchStage.sv
regFile.sv
decodeStage.sv
hazardUnit.sv
executeStage.sv
memStage.sv
cpuCore.sv
tbCpuCore.sv

// ==== Bender.yml ====
package:
  name: cpuCore

sources:
  - isaPkg.sv
  - pipePkg.sv
  - fetchStage.sv
  - regFile.sv
  - decodeStage.sv
  - hazardUnit.sv
  - executeStage.sv
  - memStage.sv
  - cpuCore.sv
  - target: test
    include_dirs:
      - .
    files:
      - tbCpuCore.sv
